// File: serial_pkg.sv
package serial_pkg;

  // One byte on the host serial link
  typedef logic [7:0] serial_byte_t;

  // Acknowledge byte returned after every DAC transfer
  function automatic serial_byte_t ack_byte(
    input serial_byte_t b_hi,
    input serial_byte_t b_mid,
    input serial_byte_t b_lo
  );
    serial_byte_t folded;
    folded = b_hi ^ b_mid;
    return folded ^ b_lo; // XOR of all three word bytes
  endfunction

endpackage

// File: mems_pkg.sv
package mems_pkg;

  localparam int DAC_BITS = 24; // One full DAC frame

  typedef logic [DAC_BITS-1:0] dac_word_t;
  typedef logic [2:0] dac_cmd_t;
  typedef logic [2:0] dac_chan_t;

  // Field positions inside dac_word_t, bits 23:22 are don't care
  localparam int CMD_MSB  = 21;
  localparam int CMD_LSB  = 19;
  localparam int CHAN_MSB = 18;
  localparam int CHAN_LSB = 16;
  localparam int DATA_MSB = 15;
  localparam int DATA_LSB = 0;

  // Channel codes of the quad DAC
  localparam dac_chan_t CHAN_X = 3'd0; // Horizontal axis
  localparam dac_chan_t CHAN_Y = 3'd1; // Vertical axis

  // Write input register and update output
  localparam dac_cmd_t CMD_WRITE_UPDATE = 3'd3;

endpackage

// File: mems_word_if.sv
`timescale 1ns/100ps

// One DAC word from the command assembler to the SPI port
interface mems_word_if;

  mems_pkg::dac_word_t word; // Held stable until done
  logic start;               // Single cycle, only while busy is low
  logic busy;                // High from the cycle after start
  logic done;                // Pulses in the cycle busy falls

  modport ctrl (
    output word,
    output start,
    input  busy,
    input  done
  );

  modport port (
    input  word,
    input  start,
    output busy,
    output done
  );

endinterface

// File: uart_rx.sv
`timescale 1ns/100ps

module uart_rx #(
  parameter int BAUD_DIV = 100
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     rx,
  output serial_pkg::serial_byte_t rx_byte,
  output logic                     rx_valid
);

  localparam int CW = $clog2(BAUD_DIV);

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

  state_t                   state;
  logic [2:0]               rx_sync;  // Two sync stages plus previous value
  logic                     rx_s;     // Synchronized line
  logic                     fall;     // Start edge
  logic [CW-1:0]            baud_cnt;
  logic [2:0]               bit_cnt;
  serial_pkg::serial_byte_t shift;

  assign rx_s    = rx_sync[1];
  assign fall    = rx_sync[2] & ~rx_sync[1];
  assign rx_byte = shift;

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_sync <= 3'b111; // Line idles high
    end else begin
      rx_sync <= {rx_sync[1:0], rx};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        IDLE: begin
          baud_cnt <= '0;
          if (fall) state <= START;
        end
        START: begin
          if (baud_cnt == CW'(BAUD_DIV / 2 - 1)) begin // Middle of start bit
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_s ? IDLE : DATA; // Glitch, not a real start
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        DATA: begin
          if (baud_cnt == CW'(BAUD_DIV - 1)) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= STOP;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: begin // STOP
          if (baud_cnt == CW'(BAUD_DIV - 1)) begin
            state    <= IDLE;
            rx_valid <= rx_s; // Framing error drops the byte
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state == DATA && baud_cnt == CW'(BAUD_DIV - 1)) shift <= {rx_s, shift[7:1]};
  end

endmodule

// File: uart_tx.sv
`timescale 1ns/100ps

module uart_tx #(
  parameter int BAUD_DIV = 100
) (
  input  logic                     clk,
  input  logic                     reset,
  input  serial_pkg::serial_byte_t tx_byte,
  input  logic                     tx_start,
  input  logic                     tx_block,
  output logic                     tx,
  output logic                     tx_busy
);

  localparam int CW = $clog2(BAUD_DIV);

  typedef enum logic [1:0] {IDLE, HOLD, SEND} state_t;

  state_t        state;
  logic [9:0]    frame;    // Stop, data, start
  logic [3:0]    bit_cnt;
  logic [CW-1:0] baud_cnt;
  logic          bit_end;

  assign bit_end = baud_cnt == CW'(BAUD_DIV - 1);
  assign tx_busy = state != IDLE; // Also high while held off by host

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      tx       <= 1'b1;
      bit_cnt  <= '0;
      baud_cnt <= '0;
    end else begin
      case (state)
        IDLE: if (tx_start) state <= HOLD;
        HOLD: begin
          baud_cnt <= '0;
          bit_cnt  <= '0;
          if (!tx_block) begin // Host buffer has room
            state <= SEND;
            tx    <= frame[0];
          end
        end
        default: begin
          baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
          if (bit_end) begin
            if (bit_cnt == 4'd9) begin
              state <= IDLE;
              tx    <= 1'b1;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              tx      <= frame[1]; // Next bit out
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && tx_start) frame <= {1'b1, tx_byte, 1'b0};
    else if (state == SEND && bit_end) frame <= {1'b1, frame[9:1]};
  end

  // Assembler must wait for the previous acknowledge to finish
  a_no_start_when_busy: assert property (@(posedge clk) disable iff (reset)
    tx_start |-> !tx_busy);

endmodule

// File: mems_control.sv
`timescale 1ns/100ps

module mems_control #(
  parameter int GAP_LIMIT = 2000
) (
  input  logic                     clk,
  input  logic                     reset,
  input  serial_pkg::serial_byte_t rx_byte,
  input  logic                     rx_valid,
  mems_word_if.ctrl                mems,
  output serial_pkg::serial_byte_t tx_byte,
  output logic                     tx_start,
  input  logic                     tx_busy,
  output logic                     new_line,
  output logic                     new_frame
);

  localparam int GW = $clog2(GAP_LIMIT + 1);

  logic [1:0]          byte_cnt;  // Bytes of the word collected so far
  logic [GW-1:0]       gap_cnt;   // Idle cycles since last byte
  logic [15:0]         head;      // Upper two bytes
  logic                ack_wait;  // Launched, ack not yet handed over
  logic                blocked;
  logic                launch;
  mems_pkg::dac_chan_t chan;
  logic                data_zero;

  // Word in flight or ack still on the wire
  assign blocked   = mems.busy | ack_wait | tx_busy;
  assign launch    = rx_valid && byte_cnt == 2'd2 && !blocked;
  assign chan      = mems.word[mems_pkg::CHAN_MSB:mems_pkg::CHAN_LSB];
  assign data_zero = mems.word[mems_pkg::DATA_MSB:mems_pkg::DATA_LSB] == '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      byte_cnt   <= '0;
      gap_cnt    <= '0;
      ack_wait   <= 1'b0;
      mems.start <= 1'b0;
      tx_start   <= 1'b0;
      new_line   <= 1'b0;
      new_frame  <= 1'b0;
    end else begin
      mems.start <= launch; // Cycle after third byte
      tx_start   <= mems.done;
      new_line   <= mems.done && chan == mems_pkg::CHAN_X;
      new_frame  <= mems.done && chan == mems_pkg::CHAN_Y && data_zero; // Back to origin
      if (rx_valid) begin
        gap_cnt  <= '0;
        byte_cnt <= (byte_cnt == 2'd2) ? 2'd0 : byte_cnt + 2'd1; // Dropped word too
      end else if (byte_cnt != 2'd0) begin
        if (gap_cnt == GW'(GAP_LIMIT)) begin
          byte_cnt <= '0; // Host went quiet mid-word
          gap_cnt  <= '0;
        end else begin
          gap_cnt <= gap_cnt + 1'b1;
        end
      end
      if (launch) ack_wait <= 1'b1;
      else if (tx_start) ack_wait <= 1'b0; // tx_busy covers it from here
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid) head <= {head[7:0], rx_byte};
    if (launch) mems.word <= {head, rx_byte}; // Stable until done
    if (mems.done) begin
      tx_byte <= serial_pkg::ack_byte(mems.word[23:16], mems.word[15:8], mems.word[7:0]);
    end
  end

  a_start_idle: assert property (@(posedge clk) disable iff (reset)
    mems.start |-> !mems.busy);

  a_one_indicator: assert property (@(posedge clk) disable iff (reset)
    !(new_line && new_frame));

endmodule

// File: mems_port.sv
`timescale 1ns/100ps

module mems_port #(
  parameter int SPI_DIV  = 32,
  parameter int FCLK_DIV = 962
) (
  input  logic      clk,
  input  logic      reset,
  mems_word_if.port mems,
  output logic      mosi,
  output logic      sck,
  output logic      cs_n,
  output logic      fclk
);

  localparam int HALF  = SPI_DIV / 2;
  localparam int DW    = $clog2(SPI_DIV);
  localparam int BW    = $clog2(mems_pkg::DAC_BITS + 1);
  localparam int FHALF = FCLK_DIV / 2;
  localparam int FW    = (FHALF > 1) ? $clog2(FHALF) : 1;

  logic [DW-1:0]       div_cnt;   // Position inside one SCK period
  logic [BW-1:0]       bit_cnt;   // SCK periods finished
  mems_pkg::dac_word_t shift;
  logic                half_tick;
  logic                period_tick;
  logic                bits_done;
  logic [FW-1:0]       fclk_cnt;

  assign half_tick   = div_cnt == DW'(HALF - 1);     // Next cycle is mid period
  assign period_tick = div_cnt == DW'(SPI_DIV - 1);
  assign bits_done   = bit_cnt == BW'(mems_pkg::DAC_BITS);
  assign mosi        = shift[mems_pkg::DAC_BITS-1];  // MSB first

  always_ff @(posedge clk) begin
    if (reset) begin
      mems.busy <= 1'b0;
      mems.done <= 1'b0;
      cs_n      <= 1'b1;
      sck       <= 1'b0;
      div_cnt   <= '0;
      bit_cnt   <= '0;
    end else begin
      mems.done <= 1'b0;
      if (!mems.busy) begin
        if (mems.start) begin
          mems.busy <= 1'b1;
          cs_n      <= 1'b0; // Select one cycle after start
          div_cnt   <= '0;
          bit_cnt   <= '0;
        end
      end else begin
        div_cnt <= period_tick ? '0 : div_cnt + 1'b1;
        if (bits_done) begin
          if (half_tick) begin // Half period after last falling edge
            mems.busy <= 1'b0;
            mems.done <= 1'b1;
            cs_n      <= 1'b1;
          end
        end else if (half_tick) begin
          sck <= 1'b1;         // DAC samples here
        end else if (period_tick) begin
          sck     <= 1'b0;
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // Data moves on the falling edge
  always_ff @(posedge clk) begin
    if (!mems.busy && mems.start) shift <= mems.word;
    else if (mems.busy && !bits_done && period_tick) shift <= shift << 1;
  end

  // Filter clock for the mirror driver, free running
  always_ff @(posedge clk) begin
    if (reset) begin
      fclk_cnt <= '0;
      fclk     <= 1'b0;
    end else if (fclk_cnt == FW'(FHALF - 1)) begin
      fclk_cnt <= '0;
      fclk     <= ~fclk;
    end else begin
      fclk_cnt <= fclk_cnt + 1'b1;
    end
  end

  a_cs_idle: assert property (@(posedge clk) disable iff (reset)
    !mems.busy |-> cs_n);

  a_sck_idle: assert property (@(posedge clk) disable iff (reset)
    cs_n |-> !sck);

endmodule

// File: mems_top.sv
`timescale 1ns/100ps

module mems_top #(
  parameter int BAUD_DIV  = 100,          // 500 kbaud at 50 MHz
  parameter int SPI_DIV   = 32,           // About 1.6 MHz SCK
  parameter int FCLK_DIV  = 962,          // About 52 kHz filter clock
  parameter int GAP_LIMIT = 20 * BAUD_DIV // Two byte times of silence
) (
  input  logic clk,
  input  logic reset,
  input  logic rx,        // From host
  output logic tx,        // To host
  input  logic tx_block,  // Host receive buffer full
  output logic mosi,
  output logic sck,
  output logic cs_n,
  output logic fclk,
  output logic new_line,
  output logic new_frame
);

  serial_pkg::serial_byte_t rx_byte;
  serial_pkg::serial_byte_t tx_byte;
  logic                     rx_valid;
  logic                     tx_start;
  logic                     tx_busy;

  mems_word_if mems_bus ();

  uart_rx #(.BAUD_DIV(BAUD_DIV)) rx_unit (
    .clk(clk), .reset(reset), .rx(rx), .rx_byte(rx_byte), .rx_valid(rx_valid)
  );

  mems_control #(.GAP_LIMIT(GAP_LIMIT)) control (
    .clk(clk), .reset(reset), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .mems(mems_bus.ctrl), .tx_byte(tx_byte), .tx_start(tx_start), .tx_busy(tx_busy),
    .new_line(new_line), .new_frame(new_frame)
  );

  mems_port #(.SPI_DIV(SPI_DIV), .FCLK_DIV(FCLK_DIV)) spi_port (
    .clk(clk), .reset(reset), .mems(mems_bus.port),
    .mosi(mosi), .sck(sck), .cs_n(cs_n), .fclk(fclk)
  );

  uart_tx #(.BAUD_DIV(BAUD_DIV)) tx_unit (
    .clk(clk), .reset(reset), .tx_byte(tx_byte), .tx_start(tx_start),
    .tx_block(tx_block), .tx(tx), .tx_busy(tx_busy)
  );

endmodule

// File: tb_mems_top.sv
`timescale 1ns/100ps

module tb_mems_top;

  localparam int BAUD_DIV    = 8;
  localparam int SPI_DIV     = 4;
  localparam int FCLK_DIV    = 10;
  localparam int GAP_LIMIT   = 200;
  localparam int TIMEOUT     = 2000; // Cycles allowed for any single wait
  localparam int WORDS       = 20;
  localparam int HOLD_CYCLES = 200;  // Host keeps tx_block high this long
  localparam int FCLK_WINDOW = 400;

  logic clk, reset, rx, tx, tx_block, mosi, sck, cs_n, fclk, new_line, new_frame;

  logic [31:0]              seed = 32'h67a2;
  int                       checks = 0;
  int                       fails = 0;
  int                       test_fails [1:6];
  mems_pkg::dac_word_t      spi_q [$];  // Words seen on mosi
  int                       edge_q [$]; // Rising sck edges per frame
  serial_pkg::serial_byte_t ack_q [$];  // Bytes decoded from tx
  mems_pkg::dac_word_t      spi_word = '0;
  int                       spi_edges = 0;
  int                       line_cnt = 0, frame_cnt = 0, fclk_toggles = 0, tx_starts = 0;
  logic                     sck_q = 1'b0, cs_n_q = 1'b1, fclk_q = 1'b0;
  logic                     tx_active = 1'b0;
  int                       tx_ticks = 0;
  logic [7:0]               tx_shift = '0;

  mems_top #(
    .BAUD_DIV(BAUD_DIV), .SPI_DIV(SPI_DIV), .FCLK_DIV(FCLK_DIV), .GAP_LIMIT(GAP_LIMIT)
  ) UUT (
    .clk(clk), .reset(reset), .rx(rx), .tx(tx), .tx_block(tx_block),
    .mosi(mosi), .sck(sck), .cs_n(cs_n), .fclk(fclk),
    .new_line(new_line), .new_frame(new_frame)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Random word, write-update command, some forced X and Y origin words
  function automatic mems_pkg::dac_word_t next_word(input int idx);
    mems_pkg::dac_word_t w;
    seed = lcg_next(seed);
    w = seed[31:8]; // Upper bits have the longer period
    w[mems_pkg::CMD_MSB:mems_pkg::CMD_LSB] = mems_pkg::CMD_WRITE_UPDATE;
    if (idx % 4 == 1) w[mems_pkg::CHAN_MSB:mems_pkg::CHAN_LSB] = mems_pkg::CHAN_X;
    if (idx % 4 == 2) begin
      w[mems_pkg::CHAN_MSB:mems_pkg::CHAN_LSB] = mems_pkg::CHAN_Y;
      w[mems_pkg::DATA_MSB:mems_pkg::DATA_LSB] = '0; // Frame restart
    end
    return w;
  endfunction

  task automatic fail_test(input int test);
    fails++;
    test_fails[test]++;
  endtask

  task automatic check_value(input int test, input string sig, input logic [31:0] exp,
                             input logic [31:0] got, input int tol);
    checks++;
    assert (got >= exp - tol && got <= exp + tol) else begin
      $display("Error at %0d ns: %s expected 0x%0h got 0x%0h", $time, sig, exp, got);
      fail_test(test);
    end
  endtask

  // Start bit, 8 data bits LSB first, stop bit
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int k = 0; k < 10; k++) begin
      @(negedge clk);
      rx = frame[k];
      repeat (BAUD_DIV - 1) @(negedge clk);
    end
  endtask

  task automatic send_word(input mems_pkg::dac_word_t w);
    send_byte(w[23:16]); // MSB first
    send_byte(w[15:8]);
    send_byte(w[7:0]);
  endtask

  task automatic wait_spi_word(input int test, output bit ok);
    int n;
    n = 0;
    while (spi_q.size() == 0 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    ok = spi_q.size() != 0;
    assert (ok) else begin
      $display("Timeout at %0d ns: no SPI frame completed on cs_n", $time);
      fail_test(test);
    end
  endtask

  task automatic wait_ack_byte(input int test, output bit ok);
    int n;
    n = 0;
    while (ack_q.size() == 0 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    ok = ack_q.size() != 0;
    assert (ok) else begin
      $display("Timeout at %0d ns: no acknowledge byte arrived on tx", $time);
      fail_test(test);
    end
  endtask

  task automatic report_test(input int test, input string name);
    $display("Test %0d %s: %s", test, name, test_fails[test] == 0 ? "passed" : "failed");
  endtask

  // DUT outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      if (!cs_n && sck && !sck_q) begin // DAC sampling edge
        spi_word = {spi_word[22:0], mosi};
        spi_edges++;
      end
      if (cs_n && !cs_n_q) begin // End of SPI frame
        spi_q.push_back(spi_word);
        edge_q.push_back(spi_edges);
        spi_edges = 0;
      end
      if (new_line) line_cnt++;
      if (new_frame) frame_cnt++;
      if (fclk != fclk_q) fclk_toggles++;
      if (!tx_active) begin
        if (!tx) begin // Start bit edge
          tx_active = 1'b1;
          tx_ticks  = 0;
          tx_starts++;
        end
      end else begin
        tx_ticks++;
        if (tx_ticks % BAUD_DIV == BAUD_DIV / 2) begin // Mid bit
          if (tx_ticks / BAUD_DIV >= 1 && tx_ticks / BAUD_DIV <= 8) begin
            tx_shift = {tx, tx_shift[7:1]};
          end else if (tx_ticks / BAUD_DIV == 9) begin
            assert (tx) else begin
              $display("Framing error at %0d ns: stop bit on tx was low", $time);
              fail_test(3);
            end
            ack_q.push_back(tx_shift);
            tx_active = 1'b0;
          end
        end
      end
    end
    sck_q  = sck;
    cs_n_q = cs_n;
    fclk_q = fclk;
  end

  initial begin
    mems_pkg::dac_word_t w;
    mems_pkg::dac_chan_t chan;
    bit                  ok;
    int                  lines0, frames0, starts0, toggles0;
    logic [7:0]          ack_exp;

    foreach (test_fails[t]) test_fails[t] = 0;
    reset    = 1'b1;
    rx       = 1'b1; // Serial line idles high
    tx_block = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);

    // Test 1 checks outputs at rest
    check_value(1, "tx", 1, tx, 0);
    check_value(1, "cs_n", 1, cs_n, 0);
    check_value(1, "sck", 0, sck, 0);
    check_value(1, "fclk", 0, fclk, 0);
    check_value(1, "new_line", 0, new_line, 0);
    check_value(1, "new_frame", 0, new_frame, 0);
    reset = 1'b0;
    report_test(1, "reset state");

    // Tests 2 to 4 share the same random words
    for (int i = 0; i < WORDS; i++) begin
      w       = next_word(i);
      chan    = w[mems_pkg::CHAN_MSB:mems_pkg::CHAN_LSB];
      ack_exp = w[23:16] ^ w[15:8] ^ w[7:0];
      lines0  = line_cnt;
      frames0 = frame_cnt;
      send_word(w);
      wait_spi_word(2, ok);
      if (ok) begin
        check_value(2, "spi word", w, spi_q.pop_front(), 0);
        check_value(2, "sck rising edges", mems_pkg::DAC_BITS, edge_q.pop_front(), 0);
      end
      wait_ack_byte(3, ok);
      if (ok) check_value(3, "tx ack byte", ack_exp, ack_q.pop_front(), 0);
      check_value(4, "new_line pulses", chan == mems_pkg::CHAN_X, line_cnt - lines0, 0);
      check_value(4, "new_frame pulses",
                  chan == mems_pkg::CHAN_Y && w[mems_pkg::DATA_MSB:mems_pkg::DATA_LSB] == 0,
                  frame_cnt - frames0, 0);
    end
    report_test(2, "word transfer");
    report_test(3, "acknowledge");
    report_test(4, "indicators");

    // Stale bytes must not merge with the next word
    seed = lcg_next(seed);
    send_byte(seed[31:24]);
    send_byte(seed[23:16]);
    repeat (GAP_LIMIT + 4 * BAUD_DIV) @(negedge clk);
    check_value(5, "spi words after partial word", 0, spi_q.size(), 0);
    tx_block = 1'b1; // Host buffer full
    w        = next_word(0);
    ack_exp  = w[23:16] ^ w[15:8] ^ w[7:0];
    send_word(w);
    wait_spi_word(5, ok);
    if (ok) begin
      check_value(5, "spi word", w, spi_q.pop_front(), 0);
      void'(edge_q.pop_front());
    end
    starts0 = tx_starts;
    repeat (HOLD_CYCLES) @(posedge clk);
    check_value(5, "tx start bits while blocked", starts0, tx_starts, 0);
    check_value(5, "spi words queued", 0, spi_q.size(), 0);
    @(negedge clk);
    tx_block = 1'b0;
    wait_ack_byte(5, ok);
    if (ok) check_value(5, "tx ack byte", ack_exp, ack_q.pop_front(), 0);
    report_test(5, "gap timeout and back-pressure");

    // Test 6 measures the filter clock rate
    @(posedge clk);
    toggles0 = fclk_toggles;
    repeat (FCLK_WINDOW) @(posedge clk);
    check_value(6, "fclk toggles", FCLK_WINDOW / (FCLK_DIV / 2), fclk_toggles - toggles0, 1);
    report_test(6, "filter clock");

    $display("Checks run: %0d, failed: %0d", checks, fails);
    if (fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: mems_top.f
serial_pkg.sv
mems_pkg.sv
mems_word_if.sv
uart_rx.sv
uart_tx.sv
mems_control.sv
mems_port.sv
mems_top.sv
tb_mems_top.sv
